// ==== list.f ====
+incdir+logic
logic/cpuPkg.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/hazardUnit.sv
logic/pipelinedCpu.sv
testbench/clockGen.sv
testbench/cpuTb.sv

// ==== logic/cpuPkg.sv ====
/*
 * Instruction word formats as one union, control bundle
 * and the three pipeline register layouts
 */
`include "cpu_settings.svh"

package cpuPkg;

   typedef struct packed {
      logic [6:0]               funct7;
      logic [`CPU_REG_BITS-1:0] rs2;
      logic [`CPU_REG_BITS-1:0] rs1;
      logic [2:0]               funct3;
      logic [`CPU_REG_BITS-1:0] rd;
      logic [6:0]               opcode;
   } rFields_t;

   typedef struct packed {
      logic [11:0]              imm;
      logic [`CPU_REG_BITS-1:0] rs1;
      logic [2:0]               funct3;
      logic [`CPU_REG_BITS-1:0] rd;
      logic [6:0]               opcode;
   } iFields_t;

   // Branch immediate is scattered over the same two slices
   typedef struct packed {
      logic [6:0]               immHi;
      logic [`CPU_REG_BITS-1:0] rs2;
      logic [`CPU_REG_BITS-1:0] rs1;
      logic [2:0]               funct3;
      logic [4:0]               immLo;
      logic [6:0]               opcode;
   } sFields_t;

   // Also the jump layout
   typedef struct packed {
      logic [19:0]              imm;
      logic [`CPU_REG_BITS-1:0] rd;
      logic [6:0]               opcode;
   } uFields_t;

   typedef union packed {
      rFields_t r;
      iFields_t i;
      sFields_t s;
      uFields_t u;
   } instWord_t;

   typedef struct packed {
      logic       regWrEn;
      logic       memWrEn;
      logic       memToReg;
      logic       useImm;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
      logic       isLui;
      logic       aluAlt;
      logic [2:0] funct3;
      logic       invalid;
   } ctrl_t;

   typedef struct packed {
      logic [`CPU_XLEN-1:0]     pc;
      logic [`CPU_XLEN-1:0]     rs1Val;
      logic [`CPU_XLEN-1:0]     rs2Val;
      logic [`CPU_XLEN-1:0]     imm;
      logic [`CPU_REG_BITS-1:0] rs1;
      logic [`CPU_REG_BITS-1:0] rs2;
      logic [`CPU_REG_BITS-1:0] rd;
      ctrl_t                    ctrl;
   } idEx_t;

   typedef struct packed {
      logic [`CPU_XLEN-1:0]     result;
      logic [`CPU_XLEN-1:0]     storeVal;
      logic [`CPU_REG_BITS-1:0] rd;
      ctrl_t                    ctrl;
   } exMem_t;

   typedef struct packed {
      logic [`CPU_XLEN-1:0]     wbVal;
      logic [`CPU_REG_BITS-1:0] rd;
      logic                     regWrEn;
      logic                     invalid;
   } memWb_t;

endpackage

// ==== logic/cpu_settings.svh ====
/*
 * Widths, opcodes and fixed instruction words of the RV32I pipeline
 * Execute operand source codes
 */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_XLEN      32
`define CPU_REGS      32
`define CPU_REG_BITS  5

// Base opcodes
`define OP_LUI     7'b0110111
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_BRANCH  7'b1100011
`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_IMM     7'b0010011
`define OP_REG     7'b0110011

// addi x0, x0, 0
`define CPU_NOP       32'h0000_0013
`define CPU_RESET_PC  32'h0000_0000

// Where an execute operand comes from
`define FWD_REG  2'b00
`define FWD_MEM  2'b01
`define FWD_WB   2'b10

`endif

// ==== logic/decodeUnit.sv ====
/*
 * Instruction decode: control bits, immediates, register fields
 * and detection of unsupported words
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decodeUnit import cpuPkg::*;
(
   input  instWord_t                i_inst,
   output ctrl_t                    o_ctrl,
   output logic [`CPU_XLEN-1:0]     o_imm,
   output logic [`CPU_REG_BITS-1:0] o_rs1,
   output logic [`CPU_REG_BITS-1:0] o_rs2,
   output logic [`CPU_REG_BITS-1:0] o_rd
);

   logic [`CPU_XLEN-1:0] immI, immS, immB, immU, immJ;
   logic                 badFunct7;
   ctrl_t                ctrl;

   assign o_rs1 = i_inst.r.rs1;
   assign o_rs2 = i_inst.r.rs2;
   assign o_rd  = i_inst.r.rd;

   assign immI = {{20{i_inst.i.imm[11]}}, i_inst.i.imm};
   assign immS = {{20{i_inst.s.immHi[6]}}, i_inst.s.immHi, i_inst.s.immLo};
   assign immB = {{20{i_inst.s.immHi[6]}}, i_inst.s.immLo[0], i_inst.s.immHi[5:0],
                  i_inst.s.immLo[4:1], 1'b0};
   assign immU = {i_inst.u.imm, 12'b0};
   assign immJ = {{12{i_inst.u.imm[19]}}, i_inst.u.imm[7:0], i_inst.u.imm[8],
                  i_inst.u.imm[18:9], 1'b0};

   assign badFunct7 = (i_inst.r.funct7 != 7'b0000000) && (i_inst.r.funct7 != 7'b0100000);

   always_comb
   begin
      ctrl = '0;
      ctrl.funct3 = i_inst.r.funct3;
      o_imm = '0;
      case (i_inst.r.opcode)
         `OP_REG:
         begin
            ctrl.regWrEn = 1'b1;
            ctrl.aluAlt = i_inst.r.funct7[5];
            // Only sub and sra have an alternate form
            ctrl.invalid = badFunct7 || (i_inst.r.funct7[5] && i_inst.r.funct3 != 3'b000 &&
                                         i_inst.r.funct3 != 3'b101);
         end
         `OP_IMM:
         begin
            ctrl.regWrEn = 1'b1;
            ctrl.useImm = 1'b1;
            o_imm = immI;
            if (i_inst.r.funct3 == 3'b001)
               ctrl.invalid = i_inst.r.funct7 != 7'b0000000;
            else if (i_inst.r.funct3 == 3'b101)
            begin
               ctrl.aluAlt = i_inst.r.funct7[5];
               ctrl.invalid = badFunct7;
            end
         end
         `OP_LOAD:
         begin
            ctrl.regWrEn = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.useImm = 1'b1;
            // Address add in the ALU
            ctrl.funct3 = 3'b000;
            o_imm = immI;
            ctrl.invalid = i_inst.i.funct3 != 3'b010;
         end
         `OP_STORE:
         begin
            ctrl.memWrEn = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.funct3 = 3'b000;
            o_imm = immS;
            ctrl.invalid = i_inst.s.funct3 != 3'b010;
         end
         `OP_BRANCH:
         begin
            ctrl.isBranch = 1'b1;
            o_imm = immB;
            ctrl.invalid = i_inst.s.funct3[2:1] == 2'b01;
         end
         `OP_JAL:
         begin
            ctrl.regWrEn = 1'b1;
            ctrl.isJal = 1'b1;
            o_imm = immJ;
         end
         `OP_JALR:
         begin
            ctrl.regWrEn = 1'b1;
            ctrl.isJalr = 1'b1;
            ctrl.useImm = 1'b1;
            o_imm = immI;
            ctrl.invalid = i_inst.i.funct3 != 3'b000;
         end
         `OP_LUI:
         begin
            ctrl.regWrEn = 1'b1;
            ctrl.isLui = 1'b1;
            o_imm = immU;
         end
         // The all-zero word lands here too
         default: ctrl.invalid = 1'b1;
      endcase
      // Illegal word travels as a bubble with only its flag set
      if (ctrl.invalid)
      begin
         ctrl = '0;
         ctrl.invalid = 1'b1;
      end
      o_ctrl = ctrl;
   end

endmodule

// ==== logic/executeUnit.sv ====
/*
 * Execute stage: ALU, branch compare, link value and jump target
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module executeUnit import cpuPkg::*;
(
   input  idEx_t                i_stage,
   input  logic [`CPU_XLEN-1:0] i_opA,
   input  logic [`CPU_XLEN-1:0] i_opB,
   output logic [`CPU_XLEN-1:0] o_result,
   output logic                 o_taken,
   output logic [`CPU_XLEN-1:0] o_target
);

   ctrl_t                ctrl;
   logic [`CPU_XLEN-1:0] aluB, alu, sra, link;
   logic [4:0]           shamt;
   logic                 eq, ltS, ltU, cond;

   assign ctrl  = i_stage.ctrl;
   assign aluB  = ctrl.useImm ? i_stage.imm : i_opB;
   assign shamt = aluB[4:0];
   assign sra   = $signed(i_opA) >>> shamt;
   assign link  = i_stage.pc + 4;

   // Branches never take the immediate, so these compare rs1 with rs2 there
   assign eq  = i_opA == aluB;
   assign ltS = $signed(i_opA) < $signed(aluB);
   assign ltU = i_opA < aluB;

   always_comb
   begin
      case (ctrl.funct3)
         3'b000: alu = ctrl.aluAlt ? i_opA - aluB : i_opA + aluB;
         3'b001: alu = i_opA << shamt;
         3'b010: alu = {{(`CPU_XLEN-1){1'b0}}, ltS};
         3'b011: alu = {{(`CPU_XLEN-1){1'b0}}, ltU};
         3'b100: alu = i_opA ^ aluB;
         3'b101: alu = ctrl.aluAlt ? sra : i_opA >> shamt;
         3'b110: alu = i_opA | aluB;
         default: alu = i_opA & aluB;
      endcase
   end

   always_comb
   begin
      case (ctrl.funct3)
         3'b000: cond = eq;
         3'b001: cond = !eq;
         3'b100: cond = ltS;
         3'b101: cond = !ltS;
         3'b110: cond = ltU;
         3'b111: cond = !ltU;
         default: cond = 1'b0;
      endcase
   end

   assign o_taken  = (ctrl.isBranch && cond) || ctrl.isJal || ctrl.isJalr;
   assign o_target = ctrl.isJalr ? {alu[`CPU_XLEN-1:1], 1'b0} : i_stage.pc + i_stage.imm;

   always_comb
   begin
      if (ctrl.isJal || ctrl.isJalr)
         o_result = link;
      else if (ctrl.isLui)
         o_result = i_stage.imm;
      else
         o_result = alu;
   end

endmodule

// ==== logic/hazardUnit.sv ====
/*
 * Operand forwarding selects for execute and the control-flow flush
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module hazardUnit import cpuPkg::*;
(
   input  idEx_t      i_idEx,
   input  exMem_t     i_exMem,
   input  memWb_t     i_memWb,
   input  logic       i_taken,
   output logic [1:0] o_fwdA,
   output logic [1:0] o_fwdB,
   output logic       o_flush
);

   function automatic logic hits(input logic wrEn, input logic [`CPU_REG_BITS-1:0] rd,
                                 input logic [`CPU_REG_BITS-1:0] src);
      return wrEn && rd != '0 && rd == src;
   endfunction

   always_comb
   begin
      // Memory stage holds the younger result
      o_fwdA = `FWD_REG;
      if (hits(i_exMem.ctrl.regWrEn, i_exMem.rd, i_idEx.rs1))
         o_fwdA = `FWD_MEM;
      else if (hits(i_memWb.regWrEn, i_memWb.rd, i_idEx.rs1))
         o_fwdA = `FWD_WB;

      o_fwdB = `FWD_REG;
      if (hits(i_exMem.ctrl.regWrEn, i_exMem.rd, i_idEx.rs2))
         o_fwdB = `FWD_MEM;
      else if (hits(i_memWb.regWrEn, i_memWb.rd, i_idEx.rs2))
         o_fwdB = `FWD_WB;
   end

   // Both younger slots hold wrong-path words
   assign o_flush = i_taken;

endmodule

// ==== logic/pipelinedCpu.sv ====
/*
 * Five-stage RV32I pipeline top level: PC, stage registers,
 * forwarding muxes and the instruction and data memory ports
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module pipelinedCpu import cpuPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic [`CPU_XLEN-1:0] i_instWord,
   input  logic [`CPU_XLEN-1:0] i_dataRd,
   output logic [`CPU_XLEN-1:0] o_instAddr,
   output logic [`CPU_XLEN-1:0] o_dataAddr,
   output logic [`CPU_XLEN-1:0] o_dataWr,
   output logic                 o_dataWrEn,
   output logic                 o_halt
);

   logic [`CPU_XLEN-1:0]     pc, ifIdPc;
   instWord_t                ifIdInst;
   idEx_t                    idEx, idExNext;
   exMem_t                   exMem, exMemNext;
   memWb_t                   memWb, memWbNext;

   ctrl_t                    decCtrl;
   logic [`CPU_XLEN-1:0]     decImm, rs1Val, rs2Val;
   logic [`CPU_REG_BITS-1:0] decRs1, decRs2, decRd;

   logic [1:0]               fwdA, fwdB;
   logic                     taken, flush;
   logic [`CPU_XLEN-1:0]     opA, opB, exResult, target, memVal;

   function automatic logic [`CPU_XLEN-1:0] pickOperand(input logic [1:0] sel,
                                                        input logic [`CPU_XLEN-1:0] regVal,
                                                        input logic [`CPU_XLEN-1:0] memStage,
                                                        input logic [`CPU_XLEN-1:0] wbStage);
      case (sel)
         `FWD_MEM: return memStage;
         `FWD_WB:  return wbStage;
         default:  return regVal;
      endcase
   endfunction

   // Fetch
   assign o_instAddr = pc;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         pc <= `CPU_RESET_PC;
         ifIdPc <= '0;
         ifIdInst <= `CPU_NOP;
      end
      else
      begin
         pc <= taken ? target : pc + 4;
         ifIdPc <= pc;
         ifIdInst <= flush ? `CPU_NOP : i_instWord;
      end
   end

   // Decode
   decodeUnit u_decodeUnit (
      .i_inst (ifIdInst),
      .o_ctrl (decCtrl),
      .o_imm  (decImm),
      .o_rs1  (decRs1),
      .o_rs2  (decRs2),
      .o_rd   (decRd)
   );

   regFile u_regFile (
      .clk      (clk),
      .rst      (rst),
      .i_rs1    (decRs1),
      .i_rs2    (decRs2),
      .i_wrAddr (memWb.rd),
      .i_wrData (memWb.wbVal),
      .i_wrEn   (memWb.regWrEn),
      .o_rs1Val (rs1Val),
      .o_rs2Val (rs2Val)
   );

   assign idExNext = '{pc: ifIdPc, rs1Val: rs1Val, rs2Val: rs2Val, imm: decImm,
                       rs1: decRs1, rs2: decRs2, rd: decRd, ctrl: decCtrl};

   // Execute
   hazardUnit u_hazardUnit (
      .i_idEx  (idEx),
      .i_exMem (exMem),
      .i_memWb (memWb),
      .i_taken (taken),
      .o_fwdA  (fwdA),
      .o_fwdB  (fwdB),
      .o_flush (flush)
   );

   assign opA = pickOperand(fwdA, idEx.rs1Val, memVal, memWb.wbVal);
   assign opB = pickOperand(fwdB, idEx.rs2Val, memVal, memWb.wbVal);

   executeUnit u_executeUnit (
      .i_stage  (idEx),
      .i_opA    (opA),
      .i_opB    (opB),
      .o_result (exResult),
      .o_taken  (taken),
      .o_target (target)
   );

   assign exMemNext = '{result: exResult, storeVal: opB, rd: idEx.rd, ctrl: idEx.ctrl};

   // Memory
   assign o_dataAddr = exMem.result;
   assign o_dataWr   = exMem.storeVal;
   assign o_dataWrEn = exMem.ctrl.memWrEn;
   assign memVal     = exMem.ctrl.memToReg ? i_dataRd : exMem.result;

   assign memWbNext = '{wbVal: memVal, rd: exMem.rd, regWrEn: exMem.ctrl.regWrEn,
                        invalid: exMem.ctrl.invalid};

   // Writeback
   assign o_halt = memWb.invalid;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         idEx <= '0;
         exMem <= '0;
         memWb <= '0;
      end
      else
      begin
         // Zero control word is a bubble
         idEx <= flush ? '0 : idExNext;
         exMem <= exMemNext;
         memWb <= memWbNext;
      end
   end

   // Pipe is empty of stores in reset and the cycle after it
   assert property (@(posedge clk) !rst |=> !o_dataWrEn)
      else $error("data write right after reset");

endmodule

// ==== logic/regFile.sv ====
/*
 * 32 x 32 register file, two combinational reads,
 * x0 hardwired to zero, same-cycle write bypass
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regFile
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`CPU_REG_BITS-1:0] i_rs1,
   input  logic [`CPU_REG_BITS-1:0] i_rs2,
   input  logic [`CPU_REG_BITS-1:0] i_wrAddr,
   input  logic [`CPU_XLEN-1:0]     i_wrData,
   input  logic                     i_wrEn,
   output logic [`CPU_XLEN-1:0]     o_rs1Val,
   output logic [`CPU_XLEN-1:0]     o_rs2Val
);

   logic [`CPU_XLEN-1:0] regs [`CPU_REGS];

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         for (int k = 0; k < `CPU_REGS; k++)
            regs[k] <= '0;
      end
      else if (i_wrEn && i_wrAddr != '0)
         regs[i_wrAddr] <= i_wrData;
   end

   // Writeback in flight wins over the stored word
   assign o_rs1Val = (i_rs1 == '0) ? '0 :
                     (i_wrEn && i_wrAddr == i_rs1) ? i_wrData : regs[i_rs1];
   assign o_rs2Val = (i_rs2 == '0) ? '0 :
                     (i_wrEn && i_wrAddr == i_rs2) ? i_wrData : regs[i_rs2];

   // Stored x0 stays zero after a write aimed at it
   assert property (@(posedge clk) disable iff (!rst)
      (i_wrEn && i_wrAddr == '0) |=> (regs[0] == '0))
      else $error("x0 storage changed by a write to it");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module cpuTb -o cpuTbSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cpuTbSim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
exit 0

// ==== testbench/clockGen.sv ====
/*
 * Testbench clock and power-on reset
 */
`timescale 1ns/1ps

module clockGen
(
   output logic o_clk,
   output logic o_rst
);

   initial
   begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;
   end

   // Low for the first four cycles
   initial
   begin
      o_rst = 1'b0;
      repeat (4) @(posedge o_clk);
      o_rst <= 1'b1;
   end

endmodule

// ==== testbench/cpuTb.sv ====
/*
 * Testbench for the pipeline: memory models, instruction encoders,
 * program loader, checks, watchdog and directed tests
 */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpuTb;

   localparam int NumTests = 5;
   localparam int CyclesPerTest = 200;

   logic        clk, genRst, testRst, rst;
   logic [31:0] instWord, dataRd, instAddr, dataAddr, dataWr;
   logic        dataWrEn, halt;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   int          nextSlot;
   int          writeCount;
   int          expStores;
   logic [31:0] expAddr [$];
   logic [31:0] expVal [$];

   assign rst = genRst & testRst;
   assign instWord = imem[instAddr[9:2]];
   assign dataRd = dmem[dataAddr[9:2]];

   clockGen u_clockGen (
      .o_clk (clk),
      .o_rst (genRst)
   );

   pipelinedCpu u_pipelinedCpu (
      .clk        (clk),
      .rst        (rst),
      .i_instWord (instWord),
      .i_dataRd   (dataRd),
      .o_instAddr (instAddr),
      .o_dataAddr (dataAddr),
      .o_dataWr   (dataWr),
      .o_dataWrEn (dataWrEn),
      .o_halt     (halt)
   );

   // Data memory writes on the edge
   always @(posedge clk)
   begin
      if (rst && dataWrEn)
      begin
         dmem[dataAddr[9:2]] <= dataWr;
         writeCount = writeCount + 1;
      end
   end

   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, `OP_REG};
   endfunction

   function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};
   endfunction

   function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
   endfunction

   function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
   endfunction

   // Reference ALU from the RV32I rules
   function automatic logic [31:0] applyOp(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   task automatic checkValue(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("error %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("sim failed");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic emit(input logic [31:0] word);
      imem[nextSlot] = word;
      nextSlot = nextSlot + 1;
   endtask

   task automatic expectWord(input logic [31:0] addr, input logic [31:0] val);
      expAddr.push_back(addr);
      expVal.push_back(val);
   endtask

   task automatic emitStore(input logic [4:0] rs, input logic [11:0] addr,
                            input logic [31:0] val);
      emit(sType(addr, rs, 5'd0));
      expectWord({20'b0, addr}, val);
      expStores = expStores + 1;
   endtask

   // lui plus addi with the upper part rounded for a negative low half
   task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
      logic [31:0] upper;
      upper = (val + 32'h800) >> 12;
      emit({upper[19:0], rd, `OP_LUI});
      emit(iType(val[11:0], rd, 3'd0, rd, `OP_IMM));
   endtask

   task automatic startTest();
      @(posedge clk);
      testRst <= 1'b0;
      @(negedge clk);
      for (int k = 0; k < 256; k++)
      begin
         imem[k] = 32'h0;
         dmem[k] <= 32'h0;
      end
      nextSlot = 0;
      writeCount = 0;
      expStores = 0;
      expAddr.delete();
      expVal.delete();
   endtask

   task automatic runProgram(input string name);
      repeat (4) @(negedge clk);
      checkValue({name, " dataWrEn in reset"}, {31'b0, dataWrEn}, 32'h0);
      checkValue({name, " halt in reset"}, {31'b0, halt}, 32'h0);
      @(posedge clk);
      testRst <= 1'b1;
      @(negedge clk);
      checkValue({name, " dataWrEn after reset"}, {31'b0, dataWrEn}, 32'h0);
      checkValue({name, " halt after reset"}, {31'b0, halt}, 32'h0);
      checkValue({name, " instAddr after reset"}, instAddr, `CPU_RESET_PC);
      while (!halt)
         @(negedge clk);
      // Let anything behind the halt word drain
      repeat (6) @(negedge clk);
      for (int k = 0; k < expAddr.size(); k++)
         checkValue($sformatf("%s word at %h", name, expAddr[k]),
                    dmem[expAddr[k][9:2]], expVal[k]);
      checkValue({name, " store count"}, writeCount, expStores);
   endtask

   task automatic testAluChain();
      logic [2:0]  regF3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
      logic        regAlt [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
      logic [2:0]  immF3 [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
      logic [31:0] acc, b;
      logic [11:0] imm;
      int          addr;
      startTest();
      acc = $urandom;
      b = $urandom;
      loadConst(5'd3, acc);
      loadConst(5'd2, b);
      addr = 0;
      for (int k = 0; k < 10; k++)
      begin
         emit(rType(regAlt[k] ? 7'h20 : 7'h00, 5'd2, 5'd3, regF3[k], 5'd3));
         acc = applyOp(regF3[k], regAlt[k], acc, b);
         emitStore(5'd3, addr[11:0], acc);
         addr = addr + 4;
      end
      for (int k = 0; k < 9; k++)
      begin
         imm = 12'($urandom);
         if (immF3[k] == 3'd1 || immF3[k] == 3'd5)
            imm = {(k == 8) ? 7'h20 : 7'h00, imm[4:0]};
         emit(iType(imm, 5'd3, immF3[k], 5'd3, `OP_IMM));
         acc = applyOp(immF3[k], k == 8, acc, {{20{imm[11]}}, imm});
         emitStore(5'd3, addr[11:0], acc);
         addr = addr + 4;
      end
      runProgram("alu chain");
   endtask

   task automatic testShiftCompare();
      logic [31:0] neg, pos;
      logic [19:0] upper;
      logic [4:0]  sh, sh2;
      startTest();
      neg = $urandom | 32'h8000_0000;
      pos = $urandom & 32'h7fff_ffff;
      upper = 20'($urandom);
      sh = 5'($urandom);
      sh2 = 5'($urandom);
      emit({upper, 5'd4, `OP_LUI});
      emitStore(5'd4, 12'h000, {upper, 12'h000});
      loadConst(5'd1, neg);
      loadConst(5'd2, pos);
      loadConst(5'd5, {27'b0, sh});
      emit(iType({7'h20, sh2}, 5'd1, 3'd5, 5'd6, `OP_IMM));
      emit(iType({7'h00, sh2}, 5'd1, 3'd5, 5'd7, `OP_IMM));
      emit(rType(7'h20, 5'd5, 5'd1, 3'd5, 5'd8));
      emit(rType(7'h00, 5'd5, 5'd1, 3'd5, 5'd9));
      emit(rType(7'h00, 5'd2, 5'd1, 3'd2, 5'd10));
      emit(rType(7'h00, 5'd1, 5'd2, 3'd2, 5'd11));
      emit(rType(7'h00, 5'd2, 5'd1, 3'd3, 5'd12));
      emit(rType(7'h00, 5'd1, 5'd2, 3'd3, 5'd13));
      emitStore(5'd6, 12'h004, $unsigned($signed(neg) >>> sh2));
      emitStore(5'd7, 12'h008, neg >> sh2);
      emitStore(5'd8, 12'h00c, $unsigned($signed(neg) >>> sh));
      emitStore(5'd9, 12'h010, neg >> sh);
      emitStore(5'd10, 12'h014, 32'd1);
      emitStore(5'd11, 12'h018, 32'd0);
      emitStore(5'd12, 12'h01c, 32'd0);
      emitStore(5'd13, 12'h020, 32'd1);
      runProgram("lui shift compare");
   endtask

   task automatic testLoadStore();
      logic [31:0] a, b;
      startTest();
      a = $urandom;
      b = $urandom;
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      emitStore(5'd1, 12'h000, a);
      emitStore(5'd2, 12'h004, b);
      emit(iType(12'h000, 5'd0, 3'd2, 5'd3, `OP_LOAD));
      emit(rType(7'h00, 5'd2, 5'd3, 3'd0, 5'd4));
      emit(iType(12'h004, 5'd0, 3'd2, 5'd5, `OP_LOAD));
      emit(rType(7'h00, 5'd4, 5'd5, 3'd0, 5'd6));
      emitStore(5'd6, 12'h008, a + b + b);
      runProgram("load store");
   endtask

   // Branch over two slots; the second is a marker store only when taken
   task automatic branchCase(input logic [2:0] f3, input logic [4:0] rsA,
                             input logic [4:0] rsB, input bit taken);
      emit(bType(13'd12, rsB, rsA, f3));
      emit(iType(12'd1, 5'd10, 3'd0, 5'd10, `OP_IMM));
      if (taken)
         emit(sType(12'h080, 5'd31, 5'd0));
      else
         emit(iType(12'd1, 5'd11, 3'd0, 5'd11, `OP_IMM));
   endtask

   task automatic testControlFlow();
      logic [31:0] jalPc, jalrPc;
      startTest();
      loadConst(5'd1, $urandom | 32'h8000_0000);
      loadConst(5'd2, $urandom & 32'h7fff_ffff);
      emit(iType(12'd0, 5'd1, 3'd0, 5'd3, `OP_IMM));
      loadConst(5'd31, 32'hdead_0bad);
      branchCase(3'd0, 5'd1, 5'd3, 1);
      branchCase(3'd0, 5'd1, 5'd2, 0);
      branchCase(3'd1, 5'd1, 5'd2, 1);
      branchCase(3'd1, 5'd1, 5'd3, 0);
      branchCase(3'd4, 5'd1, 5'd2, 1);
      branchCase(3'd4, 5'd2, 5'd1, 0);
      branchCase(3'd5, 5'd2, 5'd1, 1);
      branchCase(3'd5, 5'd1, 5'd2, 0);
      branchCase(3'd6, 5'd2, 5'd1, 1);
      branchCase(3'd6, 5'd1, 5'd2, 0);
      branchCase(3'd7, 5'd1, 5'd2, 1);
      branchCase(3'd7, 5'd2, 5'd1, 0);
      jalPc = nextSlot * 4;
      emit(jType(21'd12, 5'd20));
      emit(iType(12'd1, 5'd10, 3'd0, 5'd10, `OP_IMM));
      emit(sType(12'h080, 5'd31, 5'd0));
      jalrPc = (nextSlot + 2) * 4;
      loadConst(5'd21, jalrPc + 12);
      emit(iType(12'd0, 5'd21, 3'd0, 5'd22, `OP_JALR));
      emit(iType(12'd1, 5'd10, 3'd0, 5'd10, `OP_IMM));
      emit(sType(12'h080, 5'd31, 5'd0));
      emitStore(5'd20, 12'h000, jalPc + 4);
      emitStore(5'd22, 12'h004, jalrPc + 4);
      emitStore(5'd10, 12'h008, 32'd6);
      emitStore(5'd11, 12'h00c, 32'd6);
      expectWord(32'h080, 32'h0);
      runProgram("control flow");
   endtask

   task automatic testResetHalt();
      logic [31:0] val;
      startTest();
      val = $urandom;
      loadConst(5'd1, val);
      emitStore(5'd1, 12'h040, val);
      emit(32'h0);
      runProgram("reset halt");
   endtask

   initial
   begin
      #(NumTests * CyclesPerTest * 8);
      $display("timeout: the pipeline never raised halt in time");
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      void'($urandom(32'h94ac_a25f));
      testRst = 1'b0;
      writeCount = 0;
      nextSlot = 0;
      for (int k = 0; k < 256; k++)
      begin
         imem[k] = 32'h0;
         dmem[k] <= 32'h0;
      end
      testAluChain();
      testShiftCompare();
      testLoadStore();
      testControlFlow();
      testResetHalt();
      $display("sim passed");
      $finish;
   end

endmodule
